// ==== common/ahbSwitchPkg.sv ====
// Switch widths, port counts, address map, HTRANS codes and AHB request/response structs
package ahbSwitchPkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Address and data bus widths
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  // Number of master ports and slave ports
  localparam int masterCount = 2;
  localparam int slaveCount  = 2;

  // Bits needed to hold a master index
  localparam int masterIdBits = 1;

  ////////////////////////////////////////////////////////////
  // Basic types and address map
  ////////////////////////////////////////////////////////////

  typedef logic [addrWidth-1:0] addr_t;
  typedef logic [dataWidth-1:0] data_t;

  // Slave 0 at 0x0000_0000, slave 1 at 0x1000_0000
  localparam addr_t slaveBase [slaveCount] = '{32'h0000_0000, 32'h1000_0000};

  // Only the top nibble takes part in the decode
  localparam addr_t slaveMask [slaveCount] = '{32'hF000_0000, 32'hF000_0000};

  // HTRANS codes that the switch understands
  localparam logic [1:0] transIdle   = 2'b00;
  localparam logic [1:0] transNonseq = 2'b10;

  ////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////

  // Address phase, sel doubles as request valid inside the switch
  typedef struct packed {
    logic       sel;
    addr_t      addr;
    logic       write;
    logic [2:0] size;
    logic [1:0] trans;
  } ahbReq_t;

  // Data phase response, ready is HREADYOUT toward a master
  typedef struct packed {
    data_t rdata;
    logic  ready;
    logic  resp;
  } ahbResp_t;

  // One-hot slave select from the address decoder
  typedef logic [slaveCount-1:0] slaveSel_t;

  // One-hot master grant from a slave arbiter
  typedef logic [masterCount-1:0] masterGrant_t;

endpackage

// ==== masterPort/masterPort.sv ====
// Master port with address decode, pending request register and unmapped error response
`timescale 1ns/1ps

module masterPort
(
  input  logic                     HCLK,
  input  logic                     reset,
  input  ahbSwitchPkg::ahbReq_t    mstReq,
  input  ahbSwitchPkg::data_t      mstWdata,
  input  logic                     mstReady,
  output ahbSwitchPkg::ahbResp_t   mstResp,
  output ahbSwitchPkg::ahbReq_t    portReq,
  output ahbSwitchPkg::slaveSel_t  portSel,
  output ahbSwitchPkg::data_t      portWdata,
  input  ahbSwitchPkg::ahbResp_t   slvResp [ahbSwitchPkg::slaveCount],
  input  ahbSwitchPkg::slaveSel_t  grant
);

  // Held address phase
  ahbSwitchPkg::ahbReq_t   pendReq;
  logic                    pendValid;
  // Request seen by the slave ports
  logic                    liveValid;
  logic                    reqValid;
  ahbSwitchPkg::slaveSel_t decodeSel;
  ahbSwitchPkg::slaveSel_t slaveReady;
  logic                    forwarded;
  logic                    unmapped;
  // Data phase owner and error sequence
  ahbSwitchPkg::slaveSel_t dataSlave;
  logic                    dataActive;
  logic                    errFirst;
  logic                    errSecond;
  ahbSwitchPkg::ahbResp_t  dataResp;

  ////////////////////////////////////////////////////////////
  // Request selection and decode
  ////////////////////////////////////////////////////////////

  // New NONSEQ transfer accepted on this edge
  assign liveValid = mstReq.sel && (mstReq.trans == ahbSwitchPkg::transNonseq) && mstReady;
  assign reqValid  = pendValid || liveValid;

  // Held request has precedence over the bus
  always_comb
  begin
    portReq     = pendValid ? pendReq : mstReq;
    portReq.sel = reqValid;
    if (!reqValid)
    begin
      portReq.trans = ahbSwitchPkg::transIdle;
    end
  end

  // Masked compare against each slave base
  always_comb
  begin
    for (int s = 0; s < ahbSwitchPkg::slaveCount; s++)
    begin
      decodeSel[s] = (portReq.addr & ahbSwitchPkg::slaveMask[s]) ==
                     (ahbSwitchPkg::slaveBase[s] & ahbSwitchPkg::slaveMask[s]);
    end
  end

  assign portSel  = reqValid ? decodeSel : '0;
  assign unmapped = reqValid && (decodeSel == '0);

  // Master holds HWDATA through its own wait states
  assign portWdata = mstWdata;

  // Address phase leaves the port when granted and the slave is ready
  always_comb
  begin
    for (int s = 0; s < ahbSwitchPkg::slaveCount; s++)
    begin
      slaveReady[s] = slvResp[s].ready;
    end
  end

  assign forwarded = |(portSel & grant & slaveReady);

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  // Response of the slave that owns the data phase
  always_comb
  begin
    dataResp = '0;
    for (int s = 0; s < ahbSwitchPkg::slaveCount; s++)
    begin
      if (dataSlave[s])
      begin
        dataResp = slvResp[s];
      end
    end
  end

  always_comb
  begin
    mstResp.rdata = dataResp.rdata;
    if (errFirst)
    begin
      mstResp.ready = 1'b0;
      mstResp.resp  = 1'b1;
    end
    else if (errSecond)
    begin
      mstResp.ready = 1'b1;
      mstResp.resp  = 1'b1;
    end
    else if (pendValid)
    begin
      // Waiting for a grant
      mstResp.ready = 1'b0;
      mstResp.resp  = 1'b0;
    end
    else if (dataActive)
    begin
      mstResp.ready = dataResp.ready;
      mstResp.resp  = dataResp.resp;
    end
    else
    begin
      mstResp.ready = 1'b1;
      mstResp.resp  = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (reset)
    begin
      pendValid  <= 1'b0;
      dataActive <= 1'b0;
      dataSlave  <= '0;
      errFirst   <= 1'b0;
      errSecond  <= 1'b0;
    end
    else
    begin
      // Two cycle error on an unmapped address
      errFirst  <= unmapped;
      errSecond <= errFirst;
      // Keep showing a mapped request until it gets through
      pendValid <= reqValid && !unmapped && !forwarded;
      if (forwarded)
      begin
        dataActive <= 1'b1;
        dataSlave  <= portSel;
      end
      else if (mstResp.ready)
      begin
        dataActive <= 1'b0;
      end
    end
  end

  // Capture the bus while nothing is held
  always_ff @(posedge HCLK)
  begin
    if (!pendValid)
    begin
      pendReq <= mstReq;
    end
  end

endmodule

// ==== slavePort/slaveArbiter.sv ====
// Fixed priority arbiter that locks one slave to a master for its data phase
`timescale 1ns/1ps

module slaveArbiter
(
  input  logic                       HCLK,
  input  logic                       reset,
  input  ahbSwitchPkg::masterGrant_t request,
  input  logic                       slaveReady,
  output ahbSwitchPkg::masterGrant_t grant
);

  // Combinational winner among the requests
  ahbSwitchPkg::masterGrant_t pick;
  // Data phase owner
  ahbSwitchPkg::masterGrant_t owner;
  logic                       ownerValid;

  ////////////////////////////////////////////////////////////
  // Priority pick
  ////////////////////////////////////////////////////////////

  // Walk downward so the lowest index is the last to overwrite
  always_comb
  begin
    pick = '0;
    for (int m = ahbSwitchPkg::masterCount - 1; m >= 0; m--)
    begin
      if (request[m])
      begin
        pick    = '0;
        pick[m] = 1'b1;
      end
    end
  end

  // Locked to the owner while a data phase runs
  assign grant = ownerValid ? owner : pick;

  ////////////////////////////////////////////////////////////
  // Owner register
  ////////////////////////////////////////////////////////////

  // Slave ready ends the data phase and samples the next address
  always_ff @(posedge HCLK)
  begin
    if (reset)
    begin
      owner      <= '0;
      ownerValid <= 1'b0;
    end
    else if (slaveReady)
    begin
      owner      <= grant & request;
      ownerValid <= |(grant & request);
    end
  end

endmodule

// ==== slavePort/slavePort.sv ====
// Slave port with request collection, address and write data mux and response return
`timescale 1ns/1ps

module slavePort
(
  input  logic                       HCLK,
  input  logic                       reset,
  input  ahbSwitchPkg::ahbReq_t      portReq [ahbSwitchPkg::masterCount],
  input  logic                       portSel [ahbSwitchPkg::masterCount],
  input  ahbSwitchPkg::data_t        portWdata [ahbSwitchPkg::masterCount],
  output ahbSwitchPkg::ahbReq_t      slvReq,
  output ahbSwitchPkg::data_t        slvWdata,
  input  ahbSwitchPkg::ahbResp_t     slvResp,
  output ahbSwitchPkg::ahbResp_t     portResp,
  output ahbSwitchPkg::masterGrant_t grant
);

  // Masters that address this slave
  ahbSwitchPkg::masterGrant_t            request;
  // Granted master that also requests
  ahbSwitchPkg::masterGrant_t            active;
  // Index form of the grant
  logic [ahbSwitchPkg::masterIdBits-1:0] grantIdx;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // One bit per master port
  always_comb
  begin
    for (int m = 0; m < ahbSwitchPkg::masterCount; m++)
    begin
      request[m] = portSel[m];
    end
  end

  slaveArbiter arbiter
  (
    .HCLK       (HCLK),
    .reset      (reset),
    .request    (request),
    .slaveReady (slvResp.ready),
    .grant      (grant)
  );

  // One-hot to index
  always_comb
  begin
    grantIdx = '0;
    for (int m = 0; m < ahbSwitchPkg::masterCount; m++)
    begin
      if (grant[m])
      begin
        grantIdx = m[ahbSwitchPkg::masterIdBits-1:0];
      end
    end
  end

  assign active = grant & request;

  ////////////////////////////////////////////////////////////
  // Address phase mux
  ////////////////////////////////////////////////////////////

  // Idle transfer when the granted master has nothing for this slave
  always_comb
  begin
    slvReq = portReq[grantIdx];
    if (active == '0)
    begin
      slvReq.sel   = 1'b0;
      slvReq.trans = ahbSwitchPkg::transIdle;
    end
    else
    begin
      slvReq.sel = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////////////////////////

  // During a data phase the grant is the registered owner,
  // so the same index selects the write data
  assign slvWdata = portWdata[grantIdx];

  // Response goes to every master port, the owner picks it up
  assign portResp = slvResp;

endmodule

// ==== source/ahbSwitch.sv ====
// Two master, two slave AHB3-Lite switch top with port instances and crossbar wiring
`timescale 1ns/1ps

module ahbSwitch
(
  input  logic                   HCLK,
  input  logic                   reset,
  // Master side
  input  ahbSwitchPkg::ahbReq_t  mstReq    [ahbSwitchPkg::masterCount],
  input  ahbSwitchPkg::data_t    mstWdata  [ahbSwitchPkg::masterCount],
  input  logic                   mstReady  [ahbSwitchPkg::masterCount],
  output ahbSwitchPkg::ahbResp_t mstResp   [ahbSwitchPkg::masterCount],
  // Slave side
  output ahbSwitchPkg::ahbReq_t  slvReq    [ahbSwitchPkg::slaveCount],
  output ahbSwitchPkg::data_t    slvWdata  [ahbSwitchPkg::slaveCount],
  input  ahbSwitchPkg::ahbResp_t slvResp   [ahbSwitchPkg::slaveCount]
);

  // Master port outputs
  ahbSwitchPkg::ahbReq_t      portReq   [ahbSwitchPkg::masterCount];
  ahbSwitchPkg::slaveSel_t    portSel   [ahbSwitchPkg::masterCount];
  ahbSwitchPkg::data_t        portWdata [ahbSwitchPkg::masterCount];
  // Slave port outputs
  ahbSwitchPkg::ahbResp_t     portResp  [ahbSwitchPkg::slaveCount];
  ahbSwitchPkg::masterGrant_t slvGrant  [ahbSwitchPkg::slaveCount];
  // Transposed select and grant
  logic                       selToSlave [ahbSwitchPkg::slaveCount][ahbSwitchPkg::masterCount];
  ahbSwitchPkg::slaveSel_t    mstGrant  [ahbSwitchPkg::masterCount];

  ////////////////////////////////////////////////////////////
  // Crossbar
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < ahbSwitchPkg::slaveCount; s++)
  begin : genCross
    for (genvar m = 0; m < ahbSwitchPkg::masterCount; m++)
    begin : genMaster
      assign selToSlave[s][m] = portSel[m][s];
      assign mstGrant[m][s]   = slvGrant[s][m];
    end
  end

  ////////////////////////////////////////////////////////////
  // Ports
  ////////////////////////////////////////////////////////////

  for (genvar m = 0; m < ahbSwitchPkg::masterCount; m++)
  begin : genMasterPorts
    masterPort mstPort
    (
      .HCLK      (HCLK),
      .reset     (reset),
      .mstReq    (mstReq[m]),
      .mstWdata  (mstWdata[m]),
      .mstReady  (mstReady[m]),
      .mstResp   (mstResp[m]),
      .portReq   (portReq[m]),
      .portSel   (portSel[m]),
      .portWdata (portWdata[m]),
      .slvResp   (portResp),
      .grant     (mstGrant[m])
    );
  end

  for (genvar s = 0; s < ahbSwitchPkg::slaveCount; s++)
  begin : genSlavePorts
    slavePort slvPort
    (
      .HCLK      (HCLK),
      .reset     (reset),
      .portReq   (portReq),
      .portSel   (selToSlave[s]),
      .portWdata (portWdata),
      .slvReq    (slvReq[s]),
      .slvWdata  (slvWdata[s]),
      .slvResp   (slvResp[s]),
      .portResp  (portResp[s]),
      .grant     (slvGrant[s])
    );
  end

endmodule

// ==== test/ahbSwitch_properties.sv ====
// Bound assertions on the two-cycle error response, reset state and slave select
`timescale 1ns/1ps

module ahbSwitch_properties
(
  input logic                   HCLK,
  input logic                   reset,
  input ahbSwitchPkg::ahbResp_t mstResp [ahbSwitchPkg::masterCount],
  input ahbSwitchPkg::ahbReq_t  slvReq  [ahbSwitchPkg::slaveCount]
);

  // Error opens with ready low and closes with ready high
  for (genvar m = 0; m < ahbSwitchPkg::masterCount; m++)
  begin : genErr
    errStart: assert property (@(posedge HCLK) disable iff (reset)
      $rose(mstResp[m].resp) |-> !mstResp[m].ready)
      else $error("error response started with ready high");

    errEnd: assert property (@(posedge HCLK) disable iff (reset)
      (mstResp[m].resp && !mstResp[m].ready) |=> (mstResp[m].resp && mstResp[m].ready))
      else $error("error response second cycle missing");
  end

  for (genvar s = 0; s < ahbSwitchPkg::slaveCount; s++)
  begin : genSlv
    // Slave side is quiet right after reset
    idleAfterReset: assert property (@(posedge HCLK)
      $fell(reset) |-> (slvReq[s].trans == ahbSwitchPkg::transIdle && !slvReq[s].sel))
      else $error("slave request not idle after reset");

    // A select always carries a NONSEQ transfer in this slave's top nibble
    selTargetsSlave: assert property (@(posedge HCLK) disable iff (reset)
      slvReq[s].sel |-> (slvReq[s].trans == ahbSwitchPkg::transNonseq &&
                         slvReq[s].addr[31:28] == 4'(s)))
      else $error("slave selected without a master request for its range");
  end

endmodule

bind ahbSwitch ahbSwitch_properties props
(
  .HCLK    (HCLK),
  .reset   (reset),
  .mstResp (mstResp),
  .slvReq  (slvReq)
);

// ==== test/ahbSwitchTb.sv ====
// Switch testbench with clock, reset, slave memory models, stimulus, reference model and checkers
`timescale 1ns/1ps

module ahbSwitchTb;

  // Cycles that any single wait may take
  localparam int waitLimit = 60;

  // One completed data phase with its expected outcome
  typedef struct packed {
    logic                write;
    ahbSwitchPkg::addr_t addr;
    ahbSwitchPkg::data_t expData;
    logic                expErr;
    ahbSwitchPkg::data_t gotData;
    logic                gotErr;
  } checkItem_t;

  logic                   HCLK;
  logic                   reset;
  ahbSwitchPkg::ahbReq_t  mstReq   [ahbSwitchPkg::masterCount];
  ahbSwitchPkg::data_t    mstWdata [ahbSwitchPkg::masterCount];
  logic                   mstReady [ahbSwitchPkg::masterCount];
  ahbSwitchPkg::ahbResp_t mstResp  [ahbSwitchPkg::masterCount];
  ahbSwitchPkg::ahbReq_t  slvReq   [ahbSwitchPkg::slaveCount];
  ahbSwitchPkg::data_t    slvWdata [ahbSwitchPkg::slaveCount];
  ahbSwitchPkg::ahbResp_t slvResp  [ahbSwitchPkg::slaveCount];

  // Shadow of every mapped word the masters wrote
  ahbSwitchPkg::data_t shadow [ahbSwitchPkg::addr_t];
  // Completed transfers waiting for the checkers
  checkItem_t          resultQ [ahbSwitchPkg::masterCount][$];

  time doneM0;
  time doneM1;

  ahbSwitch uut
  (
    .HCLK     (HCLK),
    .reset    (reset),
    .mstReq   (mstReq),
    .mstWdata (mstWdata),
    .mstReady (mstReady),
    .mstResp  (mstResp),
    .slvReq   (slvReq),
    .slvWdata (slvWdata),
    .slvResp  (slvResp)
  );

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;

  // Single master per layer, so the bus HREADY is the port's HREADYOUT
  for (genvar m = 0; m < ahbSwitchPkg::masterCount; m++)
  begin : genReady
    assign mstReady[m] = mstResp[m].ready;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Word never written takes a pattern tied to every address bit
  function automatic ahbSwitchPkg::data_t fillWord(input ahbSwitchPkg::addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
  endfunction

  // Slave 0 owns 0x0xxx_xxxx, slave 1 owns 0x1xxx_xxxx, the rest is a hole
  function automatic logic unmappedAddr(input ahbSwitchPkg::addr_t a);
    return a[31:28] > 4'h1;
  endfunction

  function automatic ahbSwitchPkg::data_t expectedRead(input ahbSwitchPkg::addr_t a);
    if (unmappedAddr(a))
    begin
      return '0;
    end
    return shadow.exists(a) ? shadow[a] : fillWord(a);
  endfunction

  ////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkData(input string name, input ahbSwitchPkg::data_t got,
                           input ahbSwitchPkg::data_t exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  // Only the resp field takes part
  task automatic checkResp(input string name, input ahbSwitchPkg::ahbResp_t got,
                           input ahbSwitchPkg::ahbResp_t exp);
    if (got.resp !== exp.resp)
    begin
      $display("ERR %s got 0x%h expected 0x%h", name, got.resp, exp.resp);
      $display("TEST FAIL");
      $fatal(1, "response mismatch");
    end
  endtask

  // Global limit in case a wait loop itself is never reached
  initial
  begin
    #5ms;
    stopRun("Simulation ran past its overall time limit");
  end

  ////////////////////////////////////////////////////////////
  // Slave memory models
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < ahbSwitchPkg::slaveCount; s++)
  begin : genSlave
    // Storage by offset within the slave
    ahbSwitchPkg::data_t    mem [ahbSwitchPkg::addr_t];
    ahbSwitchPkg::ahbResp_t resp;

    assign slvResp[s] = resp;

    initial
    begin
      logic                busy;
      logic                dWrite;
      ahbSwitchPkg::addr_t dAddr;
      ahbSwitchPkg::addr_t dOffset;
      int                  waits;
      busy    = 1'b0;
      dWrite  = 1'b0;
      dAddr   = '0;
      dOffset = '0;
      waits   = 0;
      resp    = '0;
      resp.ready = 1'b1;
      forever
      begin
        @(posedge HCLK);
        if (reset)
        begin
          busy = 1'b0;
        end
        else
        begin
          // Data phase ends on this edge
          if (busy && resp.ready)
          begin
            if (dWrite)
            begin
              mem[dOffset] = slvWdata[s];
            end
            busy = 1'b0;
          end
          // New address phase
          if (resp.ready && slvReq[s].sel && slvReq[s].trans == ahbSwitchPkg::transNonseq)
          begin
            dAddr   = slvReq[s].addr;
            // The slave sees only the offset below its base
            dOffset = slvReq[s].addr & ~ahbSwitchPkg::slaveMask[s];
            dWrite  = slvReq[s].write;
            waits   = int'($urandom % 3);
            busy    = 1'b1;
          end
        end
        @(negedge HCLK);
        resp.rdata = '0;
        if (busy && waits > 0)
        begin
          resp.ready = 1'b0;
          waits--;
        end
        else
        begin
          resp.ready = 1'b1;
          if (busy && !dWrite)
          begin
            resp.rdata = mem.exists(dOffset) ? mem[dOffset] : fillWord(dAddr);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Master driver
  ////////////////////////////////////////////////////////////

  // One NONSEQ transfer as an address phase then a data phase
  task automatic transfer(input int m, input logic wr, input ahbSwitchPkg::addr_t a,
                          input ahbSwitchPkg::data_t wd, output time doneAt);
    checkItem_t            item;
    ahbSwitchPkg::ahbReq_t req;
    int                    n;
    logic                  seen;
    item         = '0;
    item.write   = wr;
    item.addr    = a;
    item.expErr  = unmappedAddr(a);
    item.expData = expectedRead(a);
    if (wr && !item.expErr)
    begin
      shadow[a] = wd;
    end
    req       = '0;
    req.sel   = 1'b1;
    req.addr  = a;
    req.write = wr;
    req.size  = 3'b010;
    req.trans = ahbSwitchPkg::transNonseq;
    @(negedge HCLK);
    mstReq[m] = req;
    seen = 1'b0;
    for (n = 0; n < waitLimit && !seen; n++)
    begin
      @(posedge HCLK);
      seen = mstResp[m].ready;
    end
    if (!seen)
    begin
      stopRun($sformatf("Master %0d address phase was never accepted", m));
    end
    @(negedge HCLK);
    mstReq[m]   = '0;
    mstWdata[m] = wd;
    seen = 1'b0;
    for (n = 0; n < waitLimit && !seen; n++)
    begin
      @(posedge HCLK);
      if (mstResp[m].ready)
      begin
        seen         = 1'b1;
        item.gotData = mstResp[m].rdata;
        item.gotErr  = mstResp[m].resp;
      end
    end
    if (!seen)
    begin
      stopRun($sformatf("Master %0d data phase never completed", m));
    end
    doneAt = $time;
    resultQ[m].push_back(item);
  endtask

  // Mixed reads and writes with each master in its own address window
  task automatic randomTraffic(input int m, input int count);
    ahbSwitchPkg::addr_t a;
    time                 t;
    for (int i = 0; i < count; i++)
    begin
      a = ($urandom % 2 == 0) ? 32'h0000_0000 : 32'h1000_0000;
      a = a | (ahbSwitchPkg::addr_t'(m) << 12) | (ahbSwitchPkg::addr_t'($urandom % 16) << 2);
      transfer(m, logic'($urandom % 2), a, $urandom, t);
      repeat (int'($urandom % 3)) @(negedge HCLK);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checkers per master
  ////////////////////////////////////////////////////////////

  for (genvar m = 0; m < ahbSwitchPkg::masterCount; m++)
  begin : genCheck
    always @(negedge HCLK)
    begin
      checkItem_t             item;
      ahbSwitchPkg::ahbResp_t gotResp;
      ahbSwitchPkg::ahbResp_t expResp;
      while (resultQ[m].size() > 0)
      begin
        item         = resultQ[m].pop_front();
        gotResp      = '0;
        gotResp.resp = item.gotErr;
        expResp      = '0;
        expResp.resp = item.expErr;
        checkResp($sformatf("mstResp[%0d].resp addr 0x%h", m, item.addr), gotResp, expResp);
        if (!item.write && !item.expErr)
        begin
          checkData($sformatf("mstResp[%0d].rdata addr 0x%h", m, item.addr),
                    item.gotData, item.expData);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    int n;
    void'($urandom(11));
    reset = 1'b1;
    for (int m = 0; m < ahbSwitchPkg::masterCount; m++)
    begin
      mstReq[m]   = '0;
      mstWdata[m] = '0;
    end
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    reset = 1'b0;

    // Write then read back words in both slaves from master 0
    for (int s = 0; s < 2; s++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        transfer(0, 1'b1, (s == 0 ? 32'h0 : 32'h1000_0000) + 32'(i * 4), $urandom, doneM0);
      end
      for (int i = 0; i < 4; i++)
      begin
        transfer(0, 1'b0, (s == 0 ? 32'h0 : 32'h1000_0000) + 32'(i * 4), '0, doneM0);
      end
    end

    // Hole in the map followed by the same offset in both slaves
    transfer(0, 1'b1, 32'h2000_0010, 32'hDEAD_BEEF, doneM0);
    transfer(0, 1'b0, 32'h2000_0010, '0, doneM0);
    transfer(0, 1'b0, 32'h0000_0010, '0, doneM0);
    transfer(0, 1'b0, 32'h1000_0010, '0, doneM0);

    // Parallel access to different slaves
    fork
      transfer(0, 1'b1, 32'h0000_0100, 32'hCAFE_0001, doneM0);
      transfer(1, 1'b1, 32'h1000_0100, 32'hCAFE_0002, doneM1);
    join
    fork
      transfer(0, 1'b0, 32'h0000_0100, '0, doneM0);
      transfer(1, 1'b0, 32'h1000_0100, '0, doneM1);
    join

    // Contention for slave 1 where master 0 has priority
    fork
      transfer(0, 1'b1, 32'h1000_0200, 32'h1234_5678, doneM0);
      transfer(1, 1'b1, 32'h1000_0300, 32'h8765_4321, doneM1);
    join
    if (doneM0 > doneM1)
    begin
      stopRun("Master 0 write finished after master 1 on a shared slave");
    end
    fork
      transfer(0, 1'b0, 32'h1000_0300, '0, doneM0);
      transfer(1, 1'b0, 32'h1000_0200, '0, doneM1);
    join
    if (doneM0 > doneM1)
    begin
      stopRun("Master 0 read finished after master 1 on a shared slave");
    end

    // Random traffic of 200 transfers in all
    fork
      randomTraffic(0, 100);
      randomTraffic(1, 100);
    join

    // Let the checkers drain
    for (n = 0; n < waitLimit && (resultQ[0].size() > 0 || resultQ[1].size() > 0); n++)
    begin
      @(posedge HCLK);
    end
    if (resultQ[0].size() > 0 || resultQ[1].size() > 0)
    begin
      stopRun("Checkers did not consume all completed transfers");
    end
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
common/ahbSwitchPkg.sv
masterPort/masterPort.sv
slavePort/slaveArbiter.sv
slavePort/slavePort.sv
source/ahbSwitch.sv
test/ahbSwitch_properties.sv
test/ahbSwitchTb.sv

// ==== Makefile ====
TOP = ahbSwitchTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
